//--- verilog/mem_pkg.sv
package mem_pkg;

    // basic widths of the RV32 memory side
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;

    // byte enable patterns, shifted by the byte offset where needed.
    localparam be_t BE_NONE = 4'b0000; // pure read.
    localparam be_t BE_BYTE = 4'b0001;
    localparam be_t BE_HALF = 4'b0011;
    localparam be_t BE_ALL  = 4'b1111;

    // pc step per fetched instruction.
    localparam addr_t INSTR_BYTES = 32'd4;

    // one request on a memory port
    typedef struct packed {
        addr_t addr;  // word aligned.
        word_t wdata;
        be_t   be;    // all zero for a read.
    } ram_req_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_e;

    // one load/store unit request
    typedef struct packed {
        logic      store;
        lsu_size_e size;
        logic      is_unsigned;
        addr_t     addr;  // byte address.
        word_t     wdata; // right aligned.
    } lsu_req_t;

    // one fetched instruction with its address
    typedef struct packed {
        addr_t pc;
        word_t instr;
    } fetch_rsp_t;

endpackage

//--- verilog/dp_ram.sv
module dp_ram #(
    parameter int MEM_WORDS = 4096
) (
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              a_valid_i,
    input  mem_pkg::ram_req_t a_req_i,
    output logic              a_ready_o,
    output mem_pkg::word_t    a_rdata_o,

    input  logic              b_valid_i,
    input  mem_pkg::ram_req_t b_req_i,
    output logic              b_ready_o,
    output mem_pkg::word_t    b_rdata_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    mem_pkg::word_t   mem [MEM_WORDS];

    logic [IDX_W-1:0] a_idx;
    logic [IDX_W-1:0] b_idx;

    // word index wraps at the memory depth.
    function automatic logic [IDX_W-1:0] word_idx(input mem_pkg::addr_t byte_addr);
        return IDX_W'((byte_addr >> 2) % MEM_WORDS);
    endfunction

    assign a_idx = word_idx(a_req_i.addr);
    assign b_idx = word_idx(b_req_i.addr);

    // port b is written last, so it wins on a shared byte
    always @(posedge clk) begin
        if (a_valid_i) begin
            for (int k = 0; k < 4; k++) begin
                if (a_req_i.be[k]) begin
                    mem[a_idx][8*k +: 8] <= a_req_i.wdata[8*k +: 8];
                end
            end
            a_rdata_o <= mem[a_idx]; // old word.
        end
        if (b_valid_i) begin
            for (int k = 0; k < 4; k++) begin
                if (b_req_i.be[k]) begin
                    mem[b_idx][8*k +: 8] <= b_req_i.wdata[8*k +: 8];
                end
            end
            b_rdata_o <= mem[b_idx]; // old word.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            a_ready_o <= 1'b0;
            b_ready_o <= 1'b0;
        end else begin
            a_ready_o <= a_valid_i; // one cycle pulse.
            b_ready_o <= b_valid_i;
        end
    end

    function automatic mem_pkg::word_t mem_read_word(input mem_pkg::addr_t byte_addr);
        return mem[word_idx(byte_addr)];
    endfunction

    function automatic void mem_write_word(input mem_pkg::addr_t byte_addr,
                                           input mem_pkg::word_t value);
        mem[word_idx(byte_addr)] = value;
    endfunction

    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        a_valid_i |-> (a_req_i.addr[1:0] == 2'b00));

    b_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        b_valid_i |-> (b_req_i.addr[1:0] == 2'b00));

endmodule

//--- verilog/fetch_unit.sv
module fetch_unit #(
    parameter mem_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_n_i,

    output logic                ram_valid_o,
    output mem_pkg::ram_req_t   ram_req_o,
    input  logic                ram_ready_i,
    input  mem_pkg::word_t      ram_rdata_i,

    output mem_pkg::fetch_rsp_t instr_o,
    output logic                instr_valid_o,
    input  logic                instr_ack_i,

    input  logic                redirect_i,
    input  mem_pkg::addr_t      redirect_pc_i
);

    mem_pkg::addr_t      pc_q;
    logic                epoch_q;

    mem_pkg::fetch_rsp_t buf_q [2];
    logic                wr_ptr_q;
    logic                rd_ptr_q;
    logic [1:0]          count_q;
    logic [1:0]          count_d;

    logic                infl_q;       // request waiting for ready.
    mem_pkg::addr_t      infl_pc_q;
    logic                infl_epoch_q;

    logic                issue;
    logic                push;
    logic                pop;

    // entries plus in-flight below two.
    assign issue = (count_q == 2'd0) || ((count_q == 2'd1) && !infl_q);
    assign push  = ram_ready_i && (infl_epoch_q == epoch_q); // stale epoch is dropped.
    assign pop   = instr_valid_o && instr_ack_i;

    assign ram_valid_o = issue;
    assign ram_req_o   = '{addr: pc_q, wdata: '0, be: mem_pkg::BE_NONE};

    assign instr_o       = buf_q[rd_ptr_q];
    assign instr_valid_o = (count_q != 2'd0);

    always_comb begin
        count_d = count_q;
        if (push && !pop) begin
            count_d = count_q + 2'd1;
        end else if (pop && !push) begin
            count_d = count_q - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q     <= RESET_PC;
            epoch_q  <= 1'b0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            infl_q   <= 1'b0;
        end else begin
            infl_q <= issue;
            if (redirect_i) begin
                pc_q     <= redirect_pc_i; // beats a same cycle ack.
                epoch_q  <= ~epoch_q;
                wr_ptr_q <= 1'b0;
                rd_ptr_q <= 1'b0;
                count_q  <= 2'd0;
            end else begin
                if (issue) begin
                    pc_q <= pc_q + mem_pkg::INSTR_BYTES;
                end
                if (push) begin
                    wr_ptr_q <= ~wr_ptr_q;
                end
                if (pop) begin
                    rd_ptr_q <= ~rd_ptr_q;
                end
                count_q <= count_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            infl_pc_q    <= pc_q;
            infl_epoch_q <= epoch_q; // old epoch if redirected now.
        end
        if (push) begin
            buf_q[wr_ptr_q] <= '{pc: infl_pc_q, instr: ram_rdata_i};
        end
    end

    occupancy_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        ({1'b0, count_q} + {2'b00, infl_q}) <= 3'd2);

    // the memory answers every fetch exactly one cycle later
    ready_follows_issue: assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_valid_o |=> ram_ready_i);

endmodule

//--- verilog/lsu.sv
module lsu (
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              lsu_valid_i,
    input  mem_pkg::lsu_req_t lsu_req_i,
    output logic              lsu_done_o,
    output logic              lsu_err_o,
    output mem_pkg::word_t    lsu_rdata_o,

    output logic              ram_valid_o,
    output mem_pkg::ram_req_t ram_req_o,
    input  logic              ram_ready_i,
    input  mem_pkg::word_t    ram_rdata_i
);

    logic [1:0]         offset;
    logic               misaligned;
    mem_pkg::be_t       store_be;

    // attributes of the access in flight
    mem_pkg::lsu_size_e pend_size_q;
    logic               pend_unsigned_q;
    logic               pend_store_q;
    logic [1:0]         pend_offset_q;
    logic               err_q;

    mem_pkg::word_t     shifted;
    logic               byte_sign;
    logic               half_sign;
    mem_pkg::word_t     load_data;

    assign offset = lsu_req_i.addr[1:0];

    always_comb begin
        case (lsu_req_i.size)
            mem_pkg::size_byte: begin
                misaligned = 1'b0;
            end
            mem_pkg::size_half: begin
                misaligned = offset[0]; // odd address.
            end
            mem_pkg::size_word: begin
                misaligned = (offset != 2'b00);
            end
            default: begin
                misaligned = 1'b1; // unused size code.
            end
        endcase
    end

    always_comb begin
        case (lsu_req_i.size)
            mem_pkg::size_byte: begin
                store_be = mem_pkg::BE_BYTE << offset;
            end
            mem_pkg::size_half: begin
                store_be = mem_pkg::BE_HALF << offset; // offset is 0 or 2 here.
            end
            default: begin
                store_be = mem_pkg::BE_ALL;
            end
        endcase
    end

    // misaligned requests never reach the memory.
    assign ram_valid_o     = lsu_valid_i && !misaligned;
    assign ram_req_o.addr  = {lsu_req_i.addr[31:2], 2'b00};
    assign ram_req_o.wdata = lsu_req_i.wdata << {offset, 3'b000};
    assign ram_req_o.be    = lsu_req_i.store ? store_be : mem_pkg::BE_NONE;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= lsu_valid_i && misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_valid_o) begin
            pend_size_q     <= lsu_req_i.size;
            pend_unsigned_q <= lsu_req_i.is_unsigned;
            pend_store_q    <= lsu_req_i.store;
            pend_offset_q   <= offset;
        end
    end

    // bring the addressed bytes down to bit 0
    assign shifted   = ram_rdata_i >> {pend_offset_q, 3'b000};
    assign byte_sign = shifted[7] & ~pend_unsigned_q;
    assign half_sign = shifted[15] & ~pend_unsigned_q;

    always_comb begin
        case (pend_size_q)
            mem_pkg::size_byte: begin
                load_data = {{24{byte_sign}}, shifted[7:0]};
            end
            mem_pkg::size_half: begin
                load_data = {{16{half_sign}}, shifted[15:0]};
            end
            default: begin
                load_data = shifted;
            end
        endcase
    end

    assign lsu_done_o  = ram_ready_i;
    assign lsu_err_o   = err_q;
    assign lsu_rdata_o = pend_store_q ? '0 : load_data; // stores return zero.

    done_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(lsu_done_o && lsu_err_o));

    // every request ends in exactly one of done or err on the next cycle
    one_result_per_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        lsu_valid_i |=> (lsu_done_o ^ lsu_err_o));

endmodule

//--- verilog/mem_subsys_top.sv
module mem_subsys_top #(
    parameter int             MEM_WORDS = 4096,
    parameter mem_pkg::addr_t RESET_PC  = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst_n_i,

    output mem_pkg::fetch_rsp_t instr_o,
    output logic                instr_valid_o,
    input  logic                instr_ack_i,
    input  logic                redirect_i,
    input  mem_pkg::addr_t      redirect_pc_i,

    input  logic                lsu_valid_i,
    input  mem_pkg::lsu_req_t   lsu_req_i,
    output logic                lsu_done_o,
    output logic                lsu_err_o,
    output mem_pkg::word_t      lsu_rdata_o
);

    // port a, instruction side.
    logic              a_valid;
    mem_pkg::ram_req_t a_req;
    logic              a_ready;
    mem_pkg::word_t    a_rdata;

    // port b, data side.
    logic              b_valid;
    mem_pkg::ram_req_t b_req;
    logic              b_ready;
    mem_pkg::word_t    b_rdata;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ram_valid_o   (a_valid),
        .ram_req_o     (a_req),
        .ram_ready_i   (a_ready),
        .ram_rdata_i   (a_rdata),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .instr_ack_i   (instr_ack_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i)
    );

    lsu lsu_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lsu_valid_i (lsu_valid_i),
        .lsu_req_i   (lsu_req_i),
        .lsu_done_o  (lsu_done_o),
        .lsu_err_o   (lsu_err_o),
        .lsu_rdata_o (lsu_rdata_o),
        .ram_valid_o (b_valid),
        .ram_req_o   (b_req),
        .ram_ready_i (b_ready),
        .ram_rdata_i (b_rdata)
    );

    dp_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) dp_ram_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .a_valid_i (a_valid),
        .a_req_i   (a_req),
        .a_ready_o (a_ready),
        .a_rdata_o (a_rdata),
        .b_valid_i (b_valid),
        .b_req_i   (b_req),
        .b_ready_o (b_ready),
        .b_rdata_o (b_rdata)
    );

endmodule

//--- test/tb_mem_subsys_tasks.svh
task automatic check_word(input string name, input mem_pkg::word_t exp,
                          input mem_pkg::word_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_fetch(input string name, input mem_pkg::fetch_rsp_t exp,
                           input mem_pkg::fetch_rsp_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected pc %h instr %h, actual pc %h instr %h",
                 name, exp.pc, exp.instr, act.pc, act.instr);
    end
endtask

task automatic check_flag(input string name, input bit exp, input bit act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
endtask

function automatic mem_pkg::word_t backdoor_read(input mem_pkg::addr_t addr);
    return mem_subsys_top_inst.dp_ram_inst.mem_read_word(addr);
endfunction

function automatic void backdoor_write(input mem_pkg::addr_t addr, input mem_pkg::word_t value);
    mem_subsys_top_inst.dp_ram_inst.mem_write_word(addr, value);
endfunction

function automatic mem_pkg::fetch_rsp_t rsp(input mem_pkg::addr_t pc, input mem_pkg::word_t w);
    mem_pkg::fetch_rsp_t r;
    r.pc    = pc;
    r.instr = w;
    return r;
endfunction

function automatic mem_pkg::lsu_req_t make_req(input bit store, input mem_pkg::lsu_size_e size,
                                               input bit uns, input mem_pkg::addr_t addr,
                                               input mem_pkg::word_t wdata);
    mem_pkg::lsu_req_t r;
    r.store       = store;
    r.size        = size;
    r.is_unsigned = uns;
    r.addr        = addr;
    r.wdata       = wdata;
    return r;
endfunction

function automatic int size_bytes(input mem_pkg::lsu_size_e size);
    case (size)
        mem_pkg::size_byte: return 1;
        mem_pkg::size_half: return 2;
        default: return 4;
    endcase
endfunction

function automatic bit is_aligned(input mem_pkg::lsu_size_e size, input int off);
    return (off % size_bytes(size)) == 0;
endfunction

// enabled bytes take the low bytes of the store data.
function automatic mem_pkg::word_t merge_store(input mem_pkg::word_t old,
                                               input mem_pkg::lsu_req_t req);
    mem_pkg::word_t res;
    int             off;
    res = old;
    off = req.addr[1:0];
    for (int k = 0; k < size_bytes(req.size); k++) begin
        res[8*(off+k) +: 8] = req.wdata[8*k +: 8];
    end
    return res;
endfunction

function automatic mem_pkg::word_t expect_load(input mem_pkg::word_t word,
                                               input mem_pkg::lsu_req_t req);
    mem_pkg::word_t res;
    int             off;
    int             n;
    off = req.addr[1:0];
    n   = size_bytes(req.size);
    res = '0;
    for (int k = 0; k < 4; k++) begin
        if (k < n) begin
            res[8*k +: 8] = word[8*(off+k) +: 8];
        end else if (!req.is_unsigned && word[8*(off+n)-1]) begin
            res[8*k +: 8] = 8'hff; // sign fill.
        end
    end
    return res;
endfunction

task automatic redirect_to(input mem_pkg::addr_t pc);
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    step();
    redirect_i    = 1'b0;
endtask

task automatic fetch_next(input string name, input mem_pkg::fetch_rsp_t exp, input int gap);
    int waited;
    waited = 0;
    while (!instr_valid_o) begin
        step();
        waited++;
        if (waited > WAIT_LIMIT) begin
            timeout_abort({name, ": no instruction delivered"});
        end
    end
    repeat (gap) step(); // head holds while the consumer stalls.
    check_fetch(name, exp, instr_o);
    instr_ack_i = 1'b1;
    step();
    instr_ack_i = 1'b0;
endtask

task automatic lsu_op(input string name, input mem_pkg::lsu_req_t req, input bit exp_err,
                      input mem_pkg::word_t exp_rdata);
    int cycles;
    cycles      = 0;
    lsu_valid_i = 1'b1;
    lsu_req_i   = req;
    do begin
        step();
        lsu_valid_i = 1'b0;
        cycles++;
        if (cycles > WAIT_LIMIT) begin
            timeout_abort({name, ": neither done nor error pulsed"});
        end
    end while (!lsu_done_o && !lsu_err_o);
    check_word({name, " latency"}, 32'd1, cycles);
    check_flag({name, " err"}, exp_err, lsu_err_o);
    check_flag({name, " done"}, !exp_err, lsu_done_o);
    if (!exp_err) begin
        check_word({name, " rdata"}, exp_rdata, lsu_rdata_o);
    end
    step();
    check_flag({name, " single pulse"}, 1'b0, lsu_done_o || lsu_err_o);
endtask

task automatic test_sequential_fetch();
    mem_pkg::word_t prog [16];
    int             gap;
    for (int i = 0; i < 16; i++) begin
        prog[i] = next_rand();
        backdoor_write(RESET_PC + 4 * i, prog[i]);
    end
    for (int i = 0; i < 16; i++) begin
        gap = (i < 8) ? 0 : int'(next_rand() % 4);
        fetch_next($sformatf("seq_fetch %0d", i), rsp(RESET_PC + 4 * i, prog[i]), gap);
    end
endtask

task automatic test_redirect();
    mem_pkg::addr_t target;
    mem_pkg::word_t w0;
    mem_pkg::word_t w1;
    target = 32'h0000_0200 + ((next_rand() % 64) << 2);
    w0     = next_rand();
    w1     = next_rand();
    backdoor_write(target, w0);
    backdoor_write(target + 4, w1);
    repeat (4) step(); // buffer fills.
    instr_ack_i = 1'b1;
    step();
    redirect_to(target); // a fetch issues on this edge while ack is high.
    instr_ack_i = 1'b0;
    check_flag("redirect flush", 1'b0, instr_valid_o);
    fetch_next("redirect first", rsp(target, w0), 0);
    fetch_next("redirect second", rsp(target + 4, w1), 0);
endtask

task automatic test_store_load();
    mem_pkg::lsu_req_t req;
    mem_pkg::addr_t    addr;
    mem_pkg::word_t    model;
    string             name;
    int                idx;
    idx = 0;
    for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off++) begin
            if (is_aligned(mem_pkg::lsu_size_e'(s), off)) begin
                addr  = DATA_BASE + 4 * idx + off;
                model = next_rand();
                backdoor_write(addr, model);
                req   = make_req(1'b1, mem_pkg::lsu_size_e'(s), 1'b0, addr, next_rand());
                model = merge_store(model, req);
                name  = $sformatf("store size %0d off %0d", s, off);
                lsu_op(name, req, 1'b0, 32'h0);
                check_word({name, " backdoor"}, model, backdoor_read(addr));
                req = make_req(1'b0, mem_pkg::size_word, 1'b0, addr & ~32'h3, '0);
                lsu_op({name, " word load"}, req, 1'b0, model);
                idx++;
            end
        end
    end
endtask

task automatic test_load_extension();
    mem_pkg::lsu_req_t req;
    mem_pkg::word_t    word;
    mem_pkg::addr_t    base;
    base = DATA_BASE + 32'h100;
    for (int p = 0; p < 2; p++) begin
        word = (p == 0) ? (next_rand() & 32'h7f7f_7f7f) : (next_rand() | 32'h8080_8080);
        backdoor_write(base, word);
        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    if (is_aligned(mem_pkg::lsu_size_e'(s), off)) begin
                        req = make_req(1'b0, mem_pkg::lsu_size_e'(s), u[0], base + off, '0);
                        lsu_op($sformatf("load size %0d off %0d uns %0d sign %0d",
                                         s, off, u, p), req, 1'b0, expect_load(word, req));
                    end
                end
            end
        end
    end
endtask

task automatic test_misaligned();
    mem_pkg::lsu_req_t req;
    mem_pkg::addr_t    addr;
    mem_pkg::word_t    word;
    string             name;
    for (int st = 0; st < 2; st++) begin
        for (int s = 1; s < 3; s++) begin
            for (int off = 1; off < 4; off++) begin
                if (!is_aligned(mem_pkg::lsu_size_e'(s), off)) begin
                    addr = DATA_BASE + 32'h180 + off;
                    word = next_rand();
                    backdoor_write(addr, word);
                    req  = make_req(st[0], mem_pkg::lsu_size_e'(s), 1'b0, addr, next_rand());
                    name = $sformatf("misaligned store %0d size %0d off %0d", st, s, off);
                    lsu_op(name, req, 1'b1, 32'h0);
                    if (st == 1) begin
                        check_word({name, " backdoor"}, word, backdoor_read(addr));
                    end
                end
            end
        end
    end
endtask

// fetch reads words 0..7, stores go to words 8..15, loads read both halves.
task automatic test_concurrency();
    mem_pkg::word_t model [16];
    for (int k = 0; k < 16; k++) begin
        model[k] = next_rand();
        backdoor_write(CONC_BASE + 4 * k, model[k]);
    end
    fork
        begin : lsu_stream
            mem_pkg::lsu_req_t  req;
            mem_pkg::lsu_size_e size;
            mem_pkg::word_t     exp_rdata;
            string              name;
            int                 off;
            int                 src;
            for (int n = 0; n < 16; n++) begin
                size = mem_pkg::lsu_size_e'(next_rand() % 3);
                off  = int'(next_rand() % 4);
                if (!is_aligned(size, off)) begin
                    off = 0;
                end
                if (n % 2 == 0) begin
                    req = make_req(1'b1, size, 1'b0, CONC_BASE + 4 * (8 + n / 2) + off,
                                   next_rand());
                    model[8 + n / 2] = merge_store(model[8 + n / 2], req);
                    exp_rdata = '0;
                end else begin
                    src = (n % 4 == 3) ? 8 + n / 2 : n / 2; // a word just stored or fetched.
                    req = make_req(1'b0, size, (next_rand() & 32'h1) != 0,
                                   CONC_BASE + 4 * src + off, '0);
                    exp_rdata = expect_load(model[src], req);
                end
                lsu_valid_i = 1'b1;
                lsu_req_i   = req;
                step();
                name = $sformatf("concurrent req %0d", n);
                check_flag({name, " done"}, 1'b1, lsu_done_o);
                check_flag({name, " err"}, 1'b0, lsu_err_o);
                check_word({name, " rdata"}, exp_rdata, lsu_rdata_o);
            end
            lsu_valid_i = 1'b0;
        end
        begin : fetch_stream
            redirect_to(CONC_BASE);
            for (int k = 0; k < 8; k++) begin
                fetch_next($sformatf("concurrent fetch %0d", k),
                           rsp(CONC_BASE + 4 * k, model[k]), 0);
            end
        end
    join
    redirect_to(CONC_BASE + 32); // drops words prefetched before the stores.
    for (int k = 8; k < 16; k++) begin
        fetch_next($sformatf("fetch stored %0d", k), rsp(CONC_BASE + 4 * k, model[k]), 0);
    end
endtask

//--- test/tb_mem_subsys.sv
module tb_mem_subsys;

    localparam int             MEM_WORDS   = 4096;
    localparam mem_pkg::addr_t RESET_PC    = 32'h0000_0000;
    localparam mem_pkg::addr_t DATA_BASE   = 32'h0000_0400;
    localparam mem_pkg::addr_t CONC_BASE   = 32'h0000_0800;
    localparam int             CLK_PERIOD  = 40;
    localparam int             DRIVE_DELAY = 5;
    localparam int             WAIT_LIMIT  = 50;

    logic                clk;
    logic                rst_n_i;
    mem_pkg::fetch_rsp_t instr_o;
    logic                instr_valid_o;
    logic                instr_ack_i;
    logic                redirect_i;
    mem_pkg::addr_t      redirect_pc_i;
    logic                lsu_valid_i;
    mem_pkg::lsu_req_t   lsu_req_i;
    logic                lsu_done_o;
    logic                lsu_err_o;
    mem_pkg::word_t      lsu_rdata_o;

    int                  err_cnt = 0;
    mem_pkg::word_t      rand_state = 32'hc765;

    mem_subsys_top #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) mem_subsys_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .instr_ack_i   (instr_ack_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .lsu_valid_i   (lsu_valid_i),
        .lsu_req_i     (lsu_req_i),
        .lsu_done_o    (lsu_done_o),
        .lsu_err_o     (lsu_err_o),
        .lsu_rdata_o   (lsu_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // lcg step, halves swapped since the high bits mix better.
    function automatic mem_pkg::word_t next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {rand_state[15:0], rand_state[31:16]};
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s", what);
        $display("errors: %0d check failures, 1 timeout", err_cnt);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    `include "tb_mem_subsys_tasks.svh"

    initial begin
        rst_n_i       = 1'b0;
        instr_ack_i   = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        lsu_valid_i   = 1'b0;
        lsu_req_i     = '0;
        repeat (16) step();
        rst_n_i = 1'b1;

        test_sequential_fetch(); // preloads before the first fetch edge.
        test_redirect();
        test_store_load();
        test_load_extension();
        test_misaligned();
        test_concurrency();
        step();

        $display("errors: %0d check failures, 0 timeouts", err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+test
verilog/mem_pkg.sv
verilog/dp_ram.sv
verilog/fetch_unit.sv
verilog/lsu.sv
verilog/mem_subsys_top.sv
test/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/dp_ram.sv
      - verilog/fetch_unit.sv
      - verilog/lsu.sv
      - verilog/mem_subsys_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mem_subsys.sv
